// File: verilog.f
design/keypad_pkg.sv
design/keypad_scanner.sv
design/keypad_debouncer.sv
design/key_event_port.sv
design/keypad_top.sv
test/keypad_checker.sv
test/keypad_tb.sv

// File: run.sh
#!/bin/sh
# build and run the keypad testbench with Verilator

top=keypad_tb
build_dir=obj_dir
log=sim.log
fail_msg="Test failures found"

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module "$top" \
    --Mdir "$build_dir" \
    -o "$top" \
    -f verilog.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/$top" > "$log" 2>&1
status=$?
cat "$log"

# the testbench prints its failure line before stopping
if grep -q "$fail_msg" "$log"; then
    echo "FAIL"
    exit 1
fi

# assertion errors stop the run without that line
if [ $status -ne 0 ]; then
    echo "FAIL: simulation exited with status $status"
    exit 1
fi

echo "PASS"
exit 0

// File: test/keypad_tb.sv
`timescale 1ns/1ps

module keypad_tb;

    import keypad_pkg::*;

    localparam int scan_dwell      = 4;
    localparam int debounce_cycles = 20;
    localparam int clk_period      = 100;
    localparam int key_actions     = 48;   // presses, releases and bounce pulses below
    localparam int action_clocks   = (4 * scan_dwell + debounce_cycles + 40) * 4;
    localparam int quiet_clocks    = 4 * scan_dwell + debounce_cycles + 20;
    localparam int bounce_on       = debounce_cycles / 4;

    logic        clk;
    logic        rst_n;
    logic [3:0]  col_sense;
    logic        event_ack;
    logic [3:0]  row_drive;
    logic        event_req;
    key_code_t   event_code;
    event_kind_t event_kind;
    logic        overrun;

    logic        key_down;   // keypad model holds one key at most
    int          key_r;
    int          key_c;
    logic        hold_ack;   // host stalls while set
    logic [4:0]  exp_q[$];   // {kind, code}
    logic [4:0]  got_q[$];

    keypad_top #(
        .scan_dwell      (scan_dwell),
        .debounce_cycles (debounce_cycles)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .col_sense  (col_sense),
        .event_ack  (event_ack),
        .row_drive  (row_drive),
        .event_req  (event_req),
        .event_code (event_code),
        .event_kind (event_kind),
        .overrun    (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "run stopped");
    endtask

    // resume 1 ns after the n-th rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic set_key(input int r, input int c, input logic down);
        @(posedge clk);
        key_r    = r;
        key_c    = c;
        key_down = down;
    endtask

    task automatic expect_event(input event_kind_t kind, input int r, input int c);
        exp_q.push_back({kind, 4'(r * 4 + c)});
    endtask

    // until every expected event came back and the bus is idle
    task automatic drain_events();
        while (exp_q.size() != 0)
            wait_cycles(1);
        while (event_req || event_ack)
            wait_cycles(1);
    endtask

    task automatic press_and_release(input int r, input int c);
        expect_event(KEY_PRESS, r, c);
        set_key(r, c, 1'b1);
        drain_events();
        expect_event(KEY_RELEASE, r, c);
        set_key(r, c, 1'b0);
        drain_events();
    endtask

    task automatic bounce_burst(input int r, input int c, input int pulses);
        repeat (pulses) begin
            while (row_drive[r])         // line up with the start of the row strobe
                wait_cycles(1);
            while (!row_drive[r])
                wait_cycles(1);
            set_key(r, c, 1'b1);
            wait_cycles(bounce_on);      // too short to qualify
            set_key(r, c, 1'b0);
            wait_cycles(10);
        end
    endtask

    // keypad matrix where key (r, c) shorts row r onto column c
    initial begin
        col_sense = 4'b0000;
        forever begin
            @(posedge clk);
            #1;
            if (key_down && row_drive[key_r])
                col_sense = 4'(1 << key_c);
            else
                col_sense = 4'b0000;
        end
    end

    // host side of the four-phase handshake
    initial begin
        int dly;
        void'($urandom(59962));
        event_ack = 1'b0;
        forever begin
            wait_cycles(1);
            if (event_req && !event_ack) begin
                dly = $urandom_range(7, 0);
                wait_cycles(dly);
                while (hold_ack)
                    wait_cycles(1);
                got_q.push_back({event_kind, event_code});
                event_ack = 1'b1;
                while (event_req)
                    wait_cycles(1);
                dly = $urandom_range(7, 0);
                wait_cycles(dly);
                event_ack = 1'b0;
            end
        end
    end

    // match completed handshakes against the expected events
    initial begin
        logic [4:0] got;
        logic [4:0] exp;
        forever begin
            @(posedge clk);
            #2;
            while (got_q.size() > 0) begin
                got = got_q.pop_front();
                assert (exp_q.size() > 0)
                    else abort_run($sformatf("unexpected event with code 0x%h", got[3:0]));
                exp = exp_q.pop_front();
                assert (got[4] == exp[4]) else abort_run($sformatf(
                    "CHECK FAILED event_kind expected 0x%h got 0x%h", exp[4], got[4]));
                assert (got[3:0] == exp[3:0]) else abort_run($sformatf(
                    "CHECK FAILED event_code expected 0x%h got 0x%h", exp[3:0], got[3:0]));
            end
        end
    end

    initial begin
        repeat (key_actions * action_clocks) @(posedge clk);
        abort_run("timeout: the tests did not complete in the expected time");
    end

    initial begin
        int r;
        int c;
        rst_n    = 1'b1;
        key_down = 1'b0;
        key_r    = 0;
        key_c    = 0;
        hold_ack = 1'b0;
        #1 rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        wait_cycles(2);

        for (r = 0; r < 4; r++) begin
            for (c = 0; c < 4; c++)
                press_and_release(r, c);
        end

        bounce_burst(2, 1, 4);          // must stay silent
        wait_cycles(quiet_clocks);
        assert (!event_req) else abort_run("bounce burst produced an event");

        bounce_burst(0, 3, 4);
        press_and_release(0, 3);

        assert (overrun == 1'b0)
            else abort_run($sformatf("CHECK FAILED overrun expected 0x0 got 0x%h", overrun));

        // host stalls across three edges and the last press is lost
        @(posedge clk);
        hold_ack = 1'b1;
        expect_event(KEY_PRESS, 1, 2);
        expect_event(KEY_RELEASE, 1, 2);
        set_key(1, 2, 1'b1);
        while (!event_req)
            wait_cycles(1);
        set_key(1, 2, 1'b0);
        wait_cycles(2 * scan_dwell);
        set_key(3, 0, 1'b1);
        while (!overrun)
            wait_cycles(1);
        @(posedge clk);
        hold_ack = 1'b0;
        drain_events();
        expect_event(KEY_RELEASE, 3, 0);
        set_key(3, 0, 1'b0);
        drain_events();

        wait_cycles(quiet_clocks);
        if (exp_q.size() == 0 && got_q.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run("expected events were left unmatched at the end of the run");
        end
    end

endmodule

// File: test/keypad_checker.sv
`timescale 1ns/1ps

module keypad_checker (
    input logic       clk,
    input logic       rst_n,
    input logic [3:0] row_drive,
    input logic       event_req,
    input logic       event_ack,
    input logic [3:0] event_code,
    input logic       event_kind,
    input logic       overrun
);

    // req has to wait for the host
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        event_req && !event_ack |=> event_req
    ) else $error("event_req dropped while event_ack was still low");

    // payload frozen for the whole request
    payload_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        event_req |=> !event_req || ($stable(event_code) && $stable(event_kind))
    ) else $error("event_code or event_kind changed while event_req was high");

    req_falls_after_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(event_req) |-> $past(event_ack)
    ) else $error("event_req fell without a preceding event_ack");

    // a new request needs the previous ack to be gone
    req_rises_after_ack_low: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(event_req) |-> !$past(event_ack)
    ) else $error("event_req rose before event_ack was seen low");

    row_drive_onehot: assert property (
        @(posedge clk)
        $onehot(row_drive)
    ) else $error("row_drive is not one-hot");

    outputs_quiet_in_reset: assert property (
        @(posedge clk)
        !rst_n |-> !event_req && !overrun
    ) else $error("event_req or overrun high during reset");

    // first clock out of reset starts on row 0
    state_after_reset: assert property (
        @(posedge clk)
        $rose(rst_n) |-> row_drive == 4'b0001 && !event_req && !overrun
    ) else $error("wrong row_drive, event_req or overrun right after reset");

endmodule

bind keypad_top keypad_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .row_drive  (row_drive),
    .event_req  (event_req),
    .event_ack  (event_ack),
    .event_code (event_code),
    .event_kind (event_kind),
    .overrun    (overrun)
);

// File: design/keypad_top.sv
`timescale 1ns/1ps

module keypad_top #(
    parameter int scan_dwell      = keypad_pkg::default_scan_dwell,
    parameter int debounce_cycles = keypad_pkg::default_debounce_cycles
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [3:0]               col_sense,
    input  logic                     event_ack,
    output logic [3:0]               row_drive,
    output logic                     event_req,
    output keypad_pkg::key_code_t    event_code,
    output keypad_pkg::event_kind_t  event_kind,
    output logic                     overrun
);

    // scanner to debouncer
    logic       key_pressed;
    logic [3:0] row_idx;
    logic [3:0] col_idx;

    // debouncer to event port
    logic       key_valid;
    logic [3:0] key_row;
    logic [3:0] key_col;

    keypad_scanner #(
        .scan_dwell (scan_dwell)
    ) u_scanner (
        .clk         (clk),
        .rst_n       (rst_n),
        .col_sense   (col_sense),
        .row_drive   (row_drive),
        .key_pressed (key_pressed),
        .row_idx     (row_idx),
        .col_idx     (col_idx)
    );

    keypad_debouncer #(
        .debounce_cycles (debounce_cycles)
    ) u_debouncer (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_pressed (key_pressed),
        .row_idx     (row_idx),
        .col_idx     (col_idx),
        .key_valid   (key_valid),
        .key_row     (key_row),
        .key_col     (key_col)
    );

    key_event_port u_event_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_valid  (key_valid),
        .key_row    (key_row),
        .key_col    (key_col),
        .event_ack  (event_ack),
        .event_req  (event_req),
        .event_code (event_code),
        .event_kind (event_kind),
        .overrun    (overrun)
    );

endmodule

// File: design/key_event_port.sv
`timescale 1ns/1ps

module key_event_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     key_valid,
    input  logic [3:0]               key_row,
    input  logic [3:0]               key_col,
    input  logic                     event_ack,
    output logic                     event_req,
    output keypad_pkg::key_code_t    event_code,
    output keypad_pkg::event_kind_t  event_kind,
    output logic                     overrun     // sticky until reset
);

    import keypad_pkg::*;

    port_state_t state;
    logic        kv_d;
    logic        rise;
    logic        fall;
    logic        edge_seen;
    event_kind_t edge_kind;
    key_code_t   edge_code;
    key_code_t   last_code;   // code of the press in progress
    logic        buf_valid;
    key_code_t   buf_code;
    event_kind_t buf_kind;
    logic        issue_buf;
    logic        issue_edge;
    logic        store_edge;
    logic        lose_edge;

    function automatic logic [1:0] onehot_idx(input logic [3:0] v);
        logic [1:0] idx;
        idx = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (v[i])
                idx = 2'(i);
        end
        return idx;
    endfunction

    assign rise      = key_valid & ~kv_d;
    assign fall      = ~key_valid & kv_d;
    assign edge_seen = rise | fall;
    assign edge_kind = rise ? KEY_PRESS : KEY_RELEASE;
    assign edge_code = rise ? {onehot_idx(key_row), onehot_idx(key_col)} : last_code;

    // buffered event goes first so ordering is kept
    assign issue_buf  = (state == READY) && buf_valid;
    assign issue_edge = (state == READY) && !buf_valid && edge_seen;
    assign store_edge = edge_seen && !issue_edge && (!buf_valid || issue_buf);
    assign lose_edge  = edge_seen && buf_valid && !issue_buf;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= READY;
            kv_d      <= 1'b0;
            event_req <= 1'b0;
            buf_valid <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            kv_d <= key_valid;
            case (state)
                READY: begin
                    if (issue_buf || issue_edge) begin
                        event_req <= 1'b1;
                        state     <= REQ_HIGH;
                    end
                end
                REQ_HIGH: begin
                    if (event_ack) begin
                        event_req <= 1'b0;
                        state     <= WAIT_ACK_LOW;
                    end
                end
                WAIT_ACK_LOW: if (!event_ack) state <= READY;
                default: begin
                    event_req <= 1'b0;
                    state     <= READY;
                end
            endcase
            if (store_edge)
                buf_valid <= 1'b1;
            else if (issue_buf)
                buf_valid <= 1'b0;
            if (lose_edge)
                overrun <= 1'b1;
        end
    end

    // event payload is loaded only when a req is about to rise
    always_ff @(posedge clk) begin
        if (rise)
            last_code <= edge_code;
        if (issue_buf) begin
            event_code <= buf_code;
            event_kind <= buf_kind;
        end else if (issue_edge) begin
            event_code <= edge_code;
            event_kind <= edge_kind;
        end
        if (store_edge) begin
            buf_code <= edge_code;
            buf_kind <= edge_kind;
        end
    end

endmodule

// File: design/keypad_debouncer.sv
`timescale 1ns/1ps

module keypad_debouncer #(
    parameter int debounce_cycles = keypad_pkg::default_debounce_cycles
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_pressed,  // from scanner, already synchronized
    input  logic [3:0] row_idx,
    input  logic [3:0] col_idx,
    output logic       key_valid,    // high for as long as the key is held
    output logic [3:0] key_row,
    output logic [3:0] key_col
);

    import keypad_pkg::*;

    localparam int cnt_w = (debounce_cycles > 0) ? $clog2(debounce_cycles + 1) : 1;

    debounce_state_t state;
    debounce_state_t next_state;
    logic [cnt_w-1:0] debounce_cnt;
    logic [3:0] cand_row;
    logic [3:0] cand_col;
    logic       cand_match;

    assign cand_match = (row_idx == cand_row) && (col_idx == cand_col);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            debounce_cnt <= '0;
            key_valid    <= 1'b0;
        end else begin
            state <= next_state;
            if (state == DEBOUNCE && next_state == DEBOUNCE)
                debounce_cnt <= debounce_cnt + 1'b1;
            else
                debounce_cnt <= '0;
            key_valid <= (state == HOLD);
        end
    end

    // candidate and presented key
    always_ff @(posedge clk) begin
        if (state == IDLE && next_state == DEBOUNCE) begin
            cand_row <= row_idx;
            cand_col <= col_idx;
        end
        if (state == HOLD) begin
            key_row <= cand_row;
            key_col <= cand_col;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (key_pressed) next_state = DEBOUNCE;
            DEBOUNCE: begin
                if (!key_pressed || !cand_match)
                    next_state = IDLE;  // bounced or scanner moved to another key
                else if (debounce_cnt == cnt_w'(debounce_cycles))
                    next_state = HOLD;
            end
            HOLD:     if (!key_pressed) next_state = RELEASE;
            RELEASE:  if (!key_pressed) next_state = IDLE;
            default:  next_state = IDLE;
        endcase
    end

endmodule

// File: design/keypad_scanner.sv
`timescale 1ns/1ps

module keypad_scanner #(
    parameter int scan_dwell = keypad_pkg::default_scan_dwell
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] col_sense,   // async straight from the keypad
    output logic [3:0] row_drive,   // one-hot and active high
    output logic       key_pressed,
    output logic [3:0] row_idx,
    output logic [3:0] col_idx
);

    import keypad_pkg::*;

    localparam int dwell_w = (scan_dwell > 1) ? $clog2(scan_dwell) : 1;

    scan_state_t  state;
    logic [dwell_w-1:0] dwell_cnt;
    logic [3:0]   col_sync1;
    logic [3:0]   col_sync2;
    logic         dwell_last;
    logic         col_active;

    // two-flop synchronizer on the column inputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_sync1 <= 4'b0000;
            col_sync2 <= 4'b0000;
        end else begin
            col_sync1 <= col_sense;
            col_sync2 <= col_sync1;
        end
    end

    assign dwell_last = (dwell_cnt == dwell_w'(scan_dwell - 1));
    assign col_active = (col_sync2 != 4'b0000);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= SCAN;
            row_drive   <= 4'b0001;  // row 0 first
            dwell_cnt   <= '0;
            key_pressed <= 1'b0;
            row_idx     <= 4'b0000;
            col_idx     <= 4'b0000;
        end else begin
            case (state)
                SCAN: begin
                    if (dwell_last) begin
                        dwell_cnt <= '0;
                        if (col_active) begin
                            // on a hit stay on this row so the index holds still
                            state       <= PARK;
                            key_pressed <= 1'b1;
                            row_idx     <= row_drive;
                            col_idx     <= col_sync2;
                        end else begin
                            row_drive <= {row_drive[2:0], row_drive[3]};
                        end
                    end else begin
                        dwell_cnt <= dwell_cnt + 1'b1;
                    end
                end

                PARK: begin
                    if (col_active) begin
                        key_pressed <= 1'b1;
                        col_idx     <= col_sync2;  // a change here makes the debouncer abort
                    end else begin
                        // columns went quiet so scanning moves on to the next row
                        state       <= SCAN;
                        key_pressed <= 1'b0;
                        dwell_cnt   <= '0;
                        row_drive   <= {row_drive[2:0], row_drive[3]};
                    end
                end

                default: begin
                    state       <= SCAN;
                    key_pressed <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: design/keypad_pkg.sv
package keypad_pkg;

    // key number is row * 4 + col from the one-hot row and col vectors
    typedef logic [3:0] key_code_t;

    // scanner either rotates the row strobe or parks on a row with an active column
    typedef enum logic {
        SCAN,
        PARK
    } scan_state_t;

    // debouncer states
    typedef enum logic [1:0] {
        IDLE,
        DEBOUNCE,
        HOLD,
        RELEASE
    } debounce_state_t;

    // event opcode sent to the host alongside the key code
    typedef enum logic {
        KEY_PRESS,
        KEY_RELEASE
    } event_kind_t;

    // four-phase handshake machine in the event port
    typedef enum logic [1:0] {
        READY,        // no event outstanding
        REQ_HIGH,     // req up, waiting for ack
        WAIT_ACK_LOW  // req dropped, waiting for host to release ack
    } port_state_t;

    // clocks each row stays strobed
    localparam int default_scan_dwell = 16;

    // about 20ms at 3MHz for real switches
    localparam int default_debounce_cycles = 60000;

endpackage
